// ==== verilog/commu_macros.svh ====
// frame buffer sizing and commit timing defines
`ifndef COMMU_MACROS_SVH
`define COMMU_MACROS_SVH

// number of frame slots
`define COMMU_SLOTS 8

// byte address width inside one slot, 256 bytes
`define COMMU_SLOT_AW 8

// cycles from frame end to commit
`define COMMU_COMMIT_DLY 8

// frame counter width, holds 0..8
`define COMMU_CNT_W 4

`endif

// ==== verilog/commu_pkg.sv ====
// shared types: 16-bit word union, producer stream, read request, framed byte stream
package commu_pkg;

	// ----------------------------------------
	// data word

	// byte view of a stored word, high byte goes first into ram
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} commu_pair_s;

	// raw on the producer side, split into bytes on the buffer side
	typedef union packed {
		logic [15:0] raw;
		commu_pair_s pair;
	} commu_word_u;

	// ----------------------------------------
	// streams

	// producer to buffer
	typedef struct packed {
		logic        frm;
		logic        vld;
		commu_word_u word;
	} commu_repk_s;

	// consumer to buffer
	typedef struct packed {
		logic frm;
		logic rd;
	} commu_rd_s;

	// framed bytes, input and output side
	typedef struct packed {
		logic       frm;
		logic       vld;
		logic [7:0] data;
	} commu_byte_s;

endpackage

// ==== verilog/commu_repack.sv ====
// byte pair packer: parity tracking, odd frame pad, delayed frame strobe
module commu_repack (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  commu_pkg::commu_byte_s in_byte,
	output commu_pkg::commu_repk_s repk
);
	import commu_pkg::*;

	logic        byte_in;
	logic        odd;
	logic        frm_in_q;
	logic        pair_done;
	logic        pad_now;
	logic [7:0]  hold_byte;
	logic        frm_r;
	logic        vld_r;
	commu_word_u word_r;

	// ----------------------------------------
	// pairing

	assign byte_in   = in_byte.frm & in_byte.vld;
	assign pair_done = byte_in & odd;
	// input frame just ended with a lone high byte
	assign pad_now   = frm_in_q & ~in_byte.frm & odd;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			odd      <= 1'b0;
			frm_in_q <= 1'b0;
			frm_r    <= 1'b0;
			vld_r    <= 1'b0;
		end else begin
			frm_in_q <= in_byte.frm;
			// stretch frm by one cycle when the pad word goes out
			frm_r    <= in_byte.frm | pad_now;
			vld_r    <= pair_done | pad_now;
			if (!in_byte.frm || pair_done) begin
				odd <= 1'b0;
			end else if (byte_in) begin
				odd <= 1'b1;
			end
		end
	end

	// first byte of a pair waits here
	always_ff @(posedge clk_sys) begin
		if (byte_in && !odd) begin
			hold_byte <= in_byte.data;
		end
		if (pair_done) begin
			word_r.raw <= {hold_byte, in_byte.data};
		end else if (pad_now) begin
			word_r.raw <= {hold_byte, 8'h00};
		end
	end

	// ----------------------------------------
	// output stream

	assign repk.frm  = frm_r;
	assign repk.vld  = vld_r;
	assign repk.word = word_r;

endmodule

// ==== verilog/commu_m_buf.sv ====
// frame buffer: commit delay, slot pointers, address counters, slot lengths, frame count, ram
`include "commu_macros.svh"

module commu_m_buf (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  commu_pkg::commu_repk_s  repk,
	input  commu_pkg::commu_rd_s    rd_req,
	output logic [7:0]              rd_q,
	output logic [`COMMU_SLOT_AW:0] rd_len,
	output logic [`COMMU_CNT_W-1:0] cnt_pkg_buf
);
	import commu_pkg::*;

	localparam int SLOT_W = $clog2(`COMMU_SLOTS);
	localparam int AW     = `COMMU_SLOT_AW;
	localparam int DLY    = `COMMU_COMMIT_DLY;
	localparam int CW     = `COMMU_CNT_W;

	logic              wfrm_q;
	logic              wfrm_fall;
	logic [DLY-1:0]    fall_dly;
	logic              commit;
	logic              rfrm_q;
	logic              rfrm_rise;
	logic              rfrm_fall;
	commu_word_u       word_q;
	logic              lo_pend;
	logic              wren;
	logic [7:0]        wdata;
	logic [AW:0]       waddr;
	logic [AW:0]       len_cap;
	logic [AW-1:0]     raddr;
	logic [SLOT_W-1:0] wr_slot;
	logic [SLOT_W-1:0] rd_slot;
	logic [AW:0]       slot_len [`COMMU_SLOTS];
	logic [7:0]        mem [`COMMU_SLOTS][2**AW];

	// ----------------------------------------
	// frame edges and commit delay

	assign wfrm_fall = wfrm_q & ~repk.frm;
	assign rfrm_rise = rd_req.frm & ~rfrm_q;
	assign rfrm_fall = rfrm_q & ~rd_req.frm;
	assign commit    = fall_dly[DLY-1];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wfrm_q   <= 1'b0;
			rfrm_q   <= 1'b0;
			fall_dly <= '0;
		end else begin
			wfrm_q   <= repk.frm;
			rfrm_q   <= rd_req.frm;
			fall_dly <= {fall_dly[DLY-2:0], wfrm_fall};
		end
	end

	// ----------------------------------------
	// write path

	// high byte on the vld cycle, low byte one cycle later
	assign wren  = repk.vld | lo_pend;
	assign wdata = repk.vld ? repk.word.pair.hi : word_q.pair.lo;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			lo_pend <= 1'b0;
			waddr   <= '0;
		end else begin
			lo_pend <= repk.vld;
			if (wren) begin
				waddr <= waddr + 1'b1;
			end else if (!repk.frm) begin
				waddr <= '0;
			end
		end
	end

	// waddr holds the full length one cycle after the frame end
	always_ff @(posedge clk_sys) begin
		if (repk.vld) begin
			word_q <= repk.word;
		end
		if (fall_dly[0]) begin
			len_cap <= waddr;
		end
	end

	// ----------------------------------------
	// slot pointers, lengths and count

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_slot     <= '0;
			rd_slot     <= '0;
			cnt_pkg_buf <= '0;
			for (int i = 0; i < `COMMU_SLOTS; i++) begin
				slot_len[i] <= '0;
			end
		end else begin
			if (commit) begin
				slot_len[wr_slot] <= len_cap;
				wr_slot           <= wr_slot + 1'b1;
			end
			// on overflow the oldest kept frame sits right after the slot just written
			if (commit && cnt_pkg_buf == CW'(`COMMU_SLOTS)) begin
				rd_slot <= wr_slot + 1'b1;
			end else if (rfrm_fall) begin
				rd_slot <= rd_slot + 1'b1;
			end
			case ({commit, rfrm_rise})
				2'b10: begin
					if (cnt_pkg_buf != CW'(`COMMU_SLOTS)) begin
						cnt_pkg_buf <= cnt_pkg_buf + 1'b1;
					end
				end
				2'b01: begin
					if (cnt_pkg_buf != '0) begin
						cnt_pkg_buf <= cnt_pkg_buf - 1'b1;
					end
				end
				default: begin
				end
			endcase
		end
	end

	assign rd_len = slot_len[rd_slot];

	// ----------------------------------------
	// read path and ram

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			raddr <= '0;
		end else if (rd_req.rd) begin
			raddr <= raddr + 1'b1;
		end else if (!rd_req.frm) begin
			raddr <= '0;
		end
	end

	// registered read, data one cycle after rd
	always_ff @(posedge clk_sys) begin
		if (wren) begin
			mem[wr_slot][waddr[AW-1:0]] <= wdata;
		end
		rd_q <= mem[rd_slot][raddr];
	end

endmodule

// ==== verilog/commu_frm_rd.sv ====
// frame reader: fsm, remaining byte counter, output byte stream
`include "commu_macros.svh"

module commu_frm_rd (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    rd_en,
	input  logic [`COMMU_CNT_W-1:0] cnt_pkg_buf,
	input  logic [`COMMU_SLOT_AW:0] rd_len,
	input  logic [7:0]              rd_q,
	output commu_pkg::commu_rd_s    rd_req,
	output commu_pkg::commu_byte_s  out_byte
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_OPEN,
		ST_READ,
		ST_CLOSE
	} state_e;

	state_e                  state;
	logic [`COMMU_SLOT_AW:0] remain;
	logic                    rd_d;

	// ----------------------------------------
	// fsm

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state  <= ST_IDLE;
			remain <= '0;
			rd_d   <= 1'b0;
		end else begin
			rd_d <= rd_req.rd;
			case (state)
				ST_IDLE: begin
					// rd_en only matters between frames
					if (rd_en && cnt_pkg_buf != '0) begin
						state <= ST_OPEN;
					end
				end
				ST_OPEN: begin
					remain <= rd_len;
					state  <= (rd_len == '0) ? ST_CLOSE : ST_READ;
				end
				ST_READ: begin
					remain <= remain - 1'b1;
					if (remain == 1) begin
						state <= ST_CLOSE;
					end
				end
				default: begin
					// frm low here, last byte still on the way out
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// ----------------------------------------
	// buffer request and output stream

	assign rd_req.frm = (state == ST_OPEN) || (state == ST_READ);
	assign rd_req.rd  = (state == ST_READ);

	assign out_byte.frm  = rd_d;
	assign out_byte.vld  = rd_d;
	assign out_byte.data = rd_q;

endmodule

// ==== verilog/commu_top.sv ====
// top level: byte packer, frame buffer and frame reader
`include "commu_macros.svh"

module commu_top (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  commu_pkg::commu_byte_s  in_byte,
	input  logic                    rd_en,
	output commu_pkg::commu_byte_s  out_byte,
	output logic [`COMMU_CNT_W-1:0] cnt_pkg_buf
);
	import commu_pkg::*;

	commu_repk_s             repk;
	commu_rd_s               rd_req;
	logic [7:0]              rd_q;
	logic [`COMMU_SLOT_AW:0] rd_len;

	commu_repack repack_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.in_byte (in_byte),
		.repk    (repk)
	);

	commu_m_buf m_buf_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.repk        (repk),
		.rd_req      (rd_req),
		.rd_q        (rd_q),
		.rd_len      (rd_len),
		.cnt_pkg_buf (cnt_pkg_buf)
	);

	commu_frm_rd frm_rd_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.rd_en       (rd_en),
		.cnt_pkg_buf (cnt_pkg_buf),
		.rd_len      (rd_len),
		.rd_q        (rd_q),
		.rd_req      (rd_req),
		.out_byte    (out_byte)
	);

endmodule

// ==== dv/commu_clkgen.sv ====
// testbench clock, 4 ns period, and reset held for two cycles
module commu_clkgen (
	output logic clk_sys,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_sys = 1'b0;
		forever begin
			#2 clk_sys = ~clk_sys;
		end
	end

	// released just after the second rising edge
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1 rst_n = 1'b1;
	end

endmodule

// ==== dv/commu_tb.sv ====
// frame buffer testbench: directed tests, expected frame queues, output monitor, timeout
`include "commu_macros.svh"

module commu_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import commu_pkg::*;

	localparam int FRAMES = 23;

	logic                    clk_sys;
	logic                    rst_n;
	commu_byte_s             in_byte;
	logic                    rd_en;
	commu_byte_s             out_byte;
	logic [`COMMU_CNT_W-1:0] cnt_pkg_buf;

	logic [7:0] exp_bytes [$];
	int         exp_lens [$];
	logic [7:0] rx_bytes [$];
	int         rx_lens [$];
	int         frame_len [FRAMES];
	int         frame_idx;
	int         total_len;
	int         cycle_limit;
	int         errors;
	int         checks;
	string      cur_test;
	int         cycles = 0;
	int         rx_cur = 0;
	int         stray_vld = 0;
	logic       mon_frm_q = 1'b0;

	commu_clkgen clkgen_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	commu_top dut_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.in_byte     (in_byte),
		.rd_en       (rd_en),
		.out_byte    (out_byte),
		.cnt_pkg_buf (cnt_pkg_buf)
	);

	// ----------------------------------------
	// output monitor and timeout

	// sampled mid-cycle, one entry per output frame
	always @(negedge clk_sys) begin
		if (rst_n) begin
			if (out_byte.vld && !out_byte.frm) begin
				stray_vld++;
			end
			if (out_byte.frm && out_byte.vld) begin
				rx_bytes.push_back(out_byte.data);
				rx_cur++;
			end
			if (mon_frm_q && !out_byte.frm) begin
				rx_lens.push_back(rx_cur);
				rx_cur = 0;
			end
			mon_frm_q = out_byte.frm;
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: output frames missing");
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// helpers

	task automatic check_equal(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	// random bytes with an occasional idle cycle, odd frames get a zero pad
	task automatic drive_frame(input bit keep);
		int         len;
		int         sent;
		logic [7:0] b;
		len = frame_len[frame_idx];
		frame_idx++;
		sent = 0;
		while (sent < len) begin
			@(posedge clk_sys);
			#1;
			in_byte.frm = 1'b1;
			if ($urandom % 8 == 0) begin
				in_byte.vld = 1'b0;
			end else begin
				b = 8'($urandom);
				in_byte.vld  = 1'b1;
				in_byte.data = b;
				if (keep) begin
					exp_bytes.push_back(b);
				end
				sent++;
			end
		end
		@(posedge clk_sys);
		#1;
		in_byte = '0;
		if (keep) begin
			if (len % 2 == 1) begin
				exp_bytes.push_back(8'h00);
			end
			exp_lens.push_back(len + len % 2);
		end
		// commit lands before the next frame starts
		repeat (`COMMU_COMMIT_DLY + 4) @(posedge clk_sys);
	endtask

	task automatic compare_frame();
		int         el;
		int         rl;
		logic [7:0] eb;
		logic [7:0] rb;
		el = exp_lens.pop_front();
		rl = rx_lens.pop_front();
		check_equal("frame length", el, rl);
		for (int i = 0; i < el || i < rl; i++) begin
			eb = 8'h00;
			rb = 8'h00;
			if (i < el) begin
				eb = exp_bytes.pop_front();
			end
			if (i < rl) begin
				rb = rx_bytes.pop_front();
			end
			if (i < el && i < rl) begin
				check_equal("data byte", eb, rb);
			end
		end
	endtask

	task automatic wait_drain();
		while (rx_lens.size() < exp_lens.size()) begin
			@(posedge clk_sys);
		end
		repeat (8) @(posedge clk_sys);
		#1;
		check_equal("frame count", exp_lens.size(), rx_lens.size());
		while (exp_lens.size() != 0 && rx_lens.size() != 0) begin
			compare_frame();
		end
		exp_lens.delete();
		exp_bytes.delete();
		rx_lens.delete();
		rx_bytes.delete();
		check_equal("vld outside frm", 0, stray_vld);
	endtask

	task automatic set_rd_en(input logic val);
		@(posedge clk_sys);
		#1;
		rd_en = val;
	endtask

	// ----------------------------------------
	// tests

	task automatic reset_state();
		cur_test = "reset_state";
		check_equal("count", 0, cnt_pkg_buf);
		check_equal("out frm", 0, out_byte.frm);
		check_equal("out vld", 0, out_byte.vld);
	endtask

	task automatic even_frames();
		cur_test = "even_frames";
		set_rd_en(1'b1);
		repeat (4) drive_frame(1'b1);
		wait_drain();
	endtask

	task automatic odd_frame_pad();
		cur_test = "odd_frame_pad";
		repeat (2) drive_frame(1'b1);
		wait_drain();
	endtask

	task automatic count_three();
		cur_test = "count_three";
		set_rd_en(1'b0);
		repeat (3) drive_frame(1'b1);
		repeat (`COMMU_COMMIT_DLY + 4) @(posedge clk_sys);
		#1;
		check_equal("count", 3, cnt_pkg_buf);
		set_rd_en(1'b1);
		wait_drain();
		check_equal("count after drain", 0, cnt_pkg_buf);
	endtask

	// the first two of ten frames are overwritten
	task automatic overflow_ten();
		cur_test = "overflow_ten";
		set_rd_en(1'b0);
		for (int k = 0; k < 10; k++) begin
			drive_frame(k >= 2);
		end
		repeat (`COMMU_COMMIT_DLY + 4) @(posedge clk_sys);
		#1;
		check_equal("count", `COMMU_SLOTS, cnt_pkg_buf);
		set_rd_en(1'b1);
		wait_drain();
		check_equal("count after drain", 0, cnt_pkg_buf);
	endtask

	task automatic back_to_back();
		cur_test = "back_to_back";
		set_rd_en(1'b0);
		repeat (2) drive_frame(1'b1);
		set_rd_en(1'b1);
		repeat (2) drive_frame(1'b1);
		wait_drain();
	endtask

	// ----------------------------------------
	// main sequence

	initial begin
		in_byte     = '0;
		rd_en       = 1'b0;
		errors      = 0;
		checks      = 0;
		frame_idx   = 0;
		total_len   = 0;
		cycle_limit = 0;
		cur_test    = "init";
		void'($urandom(32'h97a8_7b06));
		// even lengths first, then odd, then any
		for (int i = 0; i < FRAMES; i++) begin
			if (i < 4) begin
				frame_len[i] = 2 + 2 * int'($urandom % 20);
			end else if (i < 6) begin
				frame_len[i] = 1 + 2 * int'($urandom % 20);
			end else begin
				frame_len[i] = 1 + int'($urandom % 40);
			end
			total_len += frame_len[i];
		end
		cycle_limit = total_len * 4 + 2000;
		while (rst_n !== 1'b1) begin
			@(posedge clk_sys);
		end
		@(posedge clk_sys);
		#1;
		reset_state();
		even_frames();
		odd_frame_pad();
		count_three();
		overflow_ten();
		back_to_back();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== commu_top.f ====
+incdir+verilog
verilog/commu_pkg.sv
verilog/commu_repack.sv
verilog/commu_m_buf.sv
verilog/commu_frm_rd.sv
verilog/commu_top.sv
dv/commu_clkgen.sv
dv/commu_tb.sv

// ==== Makefile ====
SRCS := $(wildcard verilog/*.sv verilog/*.svh dv/*.sv)

run: obj_dir/Vcommu_tb
	@out="$$(./obj_dir/Vcommu_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

obj_dir/Vcommu_tb: commu_top.f $(SRCS)
	verilator --binary --timing --timescale 1ns/100ps --top-module commu_tb \
		-f commu_top.f -o Vcommu_tb

clean:
	rm -rf obj_dir

.PHONY: run clean
